/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_ss_router
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_ss_router_tasks.svh */
// Drive helpers, LFSR, typed compare tasks and the directed test tasks
task automatic fail_run();
  $display("SIMULATION FAILED");
  $fatal(1, "Check failed");
endtask

// Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    v    = {v[30:0], fb};
  end
  return v;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_bit(string name, logic exp, logic act);
  if (exp !== act) begin
    $display("Error at %0t: %s expected %b actual %b", $time, name, exp, act);
    fail_run();
  end
endtask

task automatic check_dest(ss_router_pkg::dest_t exp, ss_router_pkg::dest_t act);
  if (exp !== act) begin
    $display("Error at %0t: dest expected %s actual %s", $time, exp.name(), act.name());
    fail_run();
  end
endtask

task automatic check_req(ss_router_pkg::dest_t d, ss_router_pkg::l2_cmd_t cmd,
                         ss_router_pkg::ext_tag_t tag, ss_router_pkg::addr_t addr,
                         ss_router_pkg::data_t data);
  if (t_cmd[d] !== cmd) begin
    $display("Error at %0t: tgt_cmd expected %h actual %h", $time, cmd, t_cmd[d]);
    fail_run();
  end else if (t_tag[d] !== tag) begin
    $display("Error at %0t: tgt_tag expected %h actual %h", $time, tag, t_tag[d]);
    fail_run();
  end else if (t_addr[d] !== addr) begin
    $display("Error at %0t: tgt_addr expected %h actual %h", $time, addr, t_addr[d]);
    fail_run();
  end else if (t_data[d] !== data) begin
    $display("Error at %0t: tgt_data expected %h actual %h", $time, data, t_data[d]);
    fail_run();
  end
endtask

task automatic check_resp(int s, ss_router_pkg::tag_t tag, ss_router_pkg::data_t data);
  if (s_rtag[s] !== tag) begin
    $display("Error at %0t: src_rtag[%0d] expected %h actual %h", $time, s, tag, s_rtag[s]);
    fail_run();
  end else if (s_rdata[s] !== data) begin
    $display("Error at %0t: src_rdata[%0d] expected %h actual %h", $time, s, data,
             s_rdata[s]);
    fail_run();
  end
endtask

// --------------------------------------------------
// Drive helpers
// --------------------------------------------------
task automatic apply_reset();
  @(posedge i_clk);
  rst_n    <= 1'b0;
  s_valid  <= '0;
  t_rvalid <= '0;
  t_ready  <= 3'b111;
  s_rready <= 3'b111;
  repeat (8) @(posedge i_clk);
  rst_n <= 1'b1;
  // Empty slice and no pending response
  @(negedge i_clk);
  for (int i = 0; i < 3; i++) begin
    check_bit($sformatf("t_valid[%0d]", i), 1'b0, t_valid[i]);
    check_bit($sformatf("s_rvalid[%0d]", i), 1'b0, s_rvalid[i]);
    check_bit($sformatf("s_ready[%0d]", i), 1'b1, s_ready[i]);
  end
endtask

// Each window spans base through base plus mask
function automatic ss_router_pkg::dest_t expect_dest(ss_router_pkg::addr_t a);
  if (a >= `SS_CLINT_BASE && a <= `SS_CLINT_BASE + `SS_CLINT_MASK) begin
    return ss_router_pkg::DEST_CLINT;
  end
  if (a >= `SS_PLIC_BASE && a <= `SS_PLIC_BASE + `SS_PLIC_MASK) begin
    return ss_router_pkg::DEST_PLIC;
  end
  return ss_router_pkg::DEST_L2;
endfunction

function automatic ss_router_pkg::addr_t window_addr(int w, logic [31:0] r);
  if (w == 0) return `SS_CLINT_BASE | (r & `SS_CLINT_MASK);
  if (w == 1) return `SS_PLIC_BASE | (r & `SS_PLIC_MASK);
  return 32'h8000_0000 | (r & 32'h0fff_fffc);
endfunction

// Returns on the transfer edge
task automatic send_req(int s, ss_router_pkg::l2_cmd_t cmd, ss_router_pkg::tag_t tag,
                        ss_router_pkg::addr_t addr, ss_router_pkg::data_t data);
  @(posedge i_clk);
  s_valid[s] <= 1'b1;
  s_cmd[s]   <= cmd;
  s_tag[s]   <= tag;
  s_addr[s]  <= addr;
  s_data[s]  <= data;
  do begin
    @(negedge i_clk);
  end while (!s_ready[s]);
  @(posedge i_clk);
  s_valid[s] <= 1'b0;
endtask

// Sampled mid-cycle after the transfer edge
task automatic check_arrival(int s, ss_router_pkg::l2_cmd_t cmd, ss_router_pkg::tag_t tag,
                             ss_router_pkg::addr_t addr, ss_router_pkg::data_t data);
  ss_router_pkg::ext_tag_t et;
  ss_router_pkg::dest_t    d;
  et.src = ss_router_pkg::src_t'(s);
  et.tag = tag;
  d      = expect_dest(addr);
  @(negedge i_clk);
  if (t_valid == 3'b001) begin
    check_dest(d, ss_router_pkg::DEST_CLINT);
  end else if (t_valid == 3'b010) begin
    check_dest(d, ss_router_pkg::DEST_PLIC);
  end else if (t_valid == 3'b100) begin
    check_dest(d, ss_router_pkg::DEST_L2);
  end else begin
    $display("Error at %0t: no single target request valid, t_valid %b", $time, t_valid);
    fail_run();
  end
  check_req(d, cmd, et, addr, data);
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic test_decode();
  ss_router_pkg::addr_t a;
  apply_reset();
  for (int s = 0; s < 3; s++) begin
    for (int w = 0; w < 3; w++) begin
      a = window_addr(w, 32'h0012_3450 + 32'(s * 16));
      send_req(s, ss_router_pkg::CMD_RD, 4'(s * 3 + w), a, 32'hd000_0000 + 32'(w));
      check_arrival(s, ss_router_pkg::CMD_RD, 4'(s * 3 + w), a, 32'hd000_0000 + 32'(w));
    end
  end
endtask

task automatic test_round_robin();
  apply_reset();
  @(posedge i_clk);
  for (int s = 0; s < 3; s++) begin
    s_valid[s] <= 1'b1;
    s_tag[s]   <= 4'(s);
    s_addr[s]  <= 32'h8000_1000;
  end
  @(posedge i_clk);
  for (int k = 0; k < 6; k++) begin
    @(negedge i_clk);
    check_bit("l2_valid", 1'b1, t_valid[2]);
    if (t_tag[2].src !== ss_router_pkg::src_t'(k % 3)) begin
      $display("Error at %0t: l2_tag.src expected %0d actual %0d", $time, k % 3,
               t_tag[2].src);
      fail_run();
    end
  end
  @(posedge i_clk);
  s_valid <= '0;
endtask

task automatic test_back_pressure();
  apply_reset();
  @(posedge i_clk);
  t_ready[2] <= 1'b0;
  s_valid    <= 3'b011;
  s_cmd[0]   <= ss_router_pkg::CMD_RD;
  s_cmd[1]   <= ss_router_pkg::CMD_WR;
  s_tag[0]   <= 4'h1;
  s_tag[1]   <= 4'h2;
  s_addr[0]  <= 32'h8000_0100;
  s_addr[1]  <= 32'h8000_0200;
  s_data[0]  <= 32'h0000_1111;
  s_data[1]  <= 32'h0000_2222;
  // ic wins on this edge and fills the slice
  @(posedge i_clk);
  s_valid[0] <= 1'b0;
  repeat (4) begin
    @(negedge i_clk);
    check_bit("l2_valid", 1'b1, t_valid[2]);
    check_bit("ic_ready", 1'b0, s_ready[0]);
    check_bit("dc_ready", 1'b0, s_ready[1]);
    check_req(ss_router_pkg::DEST_L2, ss_router_pkg::CMD_RD, 6'h01, 32'h8000_0100,
              32'h0000_1111);
  end
  @(posedge i_clk);
  t_ready[2] <= 1'b1;
  @(negedge i_clk);
  check_req(ss_router_pkg::DEST_L2, ss_router_pkg::CMD_RD, 6'h01, 32'h8000_0100,
            32'h0000_1111);
  @(posedge i_clk);
  s_valid[1] <= 1'b0;
  @(negedge i_clk);
  check_bit("l2_valid", 1'b1, t_valid[2]);
  check_req(ss_router_pkg::DEST_L2, ss_router_pkg::CMD_WR, 6'h12, 32'h8000_0200,
            32'h0000_2222);
  @(negedge i_clk);
  check_bit("l2_valid", 1'b0, t_valid[2]);
endtask

task automatic test_resp_return();
  ss_router_pkg::ext_tag_t et;
  apply_reset();
  for (int t = 0; t < 3; t++) begin
    for (int s = 0; s < 3; s++) begin
      et.src = ss_router_pkg::src_t'(s);
      et.tag = 4'(t * 4 + s);
      @(posedge i_clk);
      t_rvalid[t] <= 1'b1;
      t_rtag[t]   <= et;
      t_rdata[t]  <= 32'hc0de_0000 + 32'(t * 16 + s);
      @(negedge i_clk);
      check_bit("src_rvalid", 1'b1, s_rvalid[s]);
      check_bit("other src_rvalid", 1'b0, |(s_rvalid & ~(3'b001 << s)));
      check_bit("tgt_rready", 1'b1, t_rready[t]);
      check_resp(s, 4'(t * 4 + s), 32'hc0de_0000 + 32'(t * 16 + s));
      @(posedge i_clk);
      t_rvalid[t] <= 1'b0;
    end
  end
endtask

task automatic test_resp_arbitration();
  apply_reset();
  @(posedge i_clk);
  s_rready[1] <= 1'b0;
  t_rvalid    <= 3'b101;
  t_rtag[0]   <= 6'h15;
  t_rdata[0]  <= 32'h0000_aaaa;
  t_rtag[2]   <= 6'h26;
  t_rdata[2]  <= 32'h0000_bbbb;
  // CLINT holds the grant while dc stalls
  repeat (3) begin
    @(negedge i_clk);
    check_bit("dc_rvalid", 1'b1, s_rvalid[1]);
    check_bit("ptw_rvalid", 1'b0, s_rvalid[2]);
    check_bit("clint_rready", 1'b0, t_rready[0]);
    check_bit("l2_rready", 1'b0, t_rready[2]);
  end
  @(posedge i_clk);
  s_rready[1] <= 1'b1;
  @(negedge i_clk);
  check_bit("clint_rready", 1'b1, t_rready[0]);
  check_resp(1, 4'h5, 32'h0000_aaaa);
  // CLINT offers another response and L2 now has priority
  @(posedge i_clk);
  t_rtag[0]  <= 6'h07;
  t_rdata[0] <= 32'h0000_cccc;
  @(negedge i_clk);
  check_bit("ptw_rvalid", 1'b1, s_rvalid[2]);
  check_bit("ic_rvalid", 1'b0, s_rvalid[0]);
  check_bit("clint_rready", 1'b0, t_rready[0]);
  check_bit("l2_rready", 1'b1, t_rready[2]);
  check_resp(2, 4'h6, 32'h0000_bbbb);
  @(posedge i_clk);
  t_rvalid[2] <= 1'b0;
  @(negedge i_clk);
  check_bit("ic_rvalid", 1'b1, s_rvalid[0]);
  check_bit("clint_rready", 1'b1, t_rready[0]);
  check_resp(0, 4'h7, 32'h0000_cccc);
  @(posedge i_clk);
  t_rvalid[0] <= 1'b0;
endtask

task automatic test_mixed_traffic();
  int                      s;
  int                      w;
  int                      seq [3];
  ss_router_pkg::addr_t    a;
  ss_router_pkg::data_t    d;
  ss_router_pkg::l2_cmd_t  c;
  apply_reset();
  seq = '{0, 0, 0};
  for (int n = 0; n < 30; n++) begin
    s = int'(rand_bits(4) % 3);
    w = int'(rand_bits(4) % 3);
    a = window_addr(w, rand_bits(28));
    d = rand_bits(32);
    c = ss_router_pkg::l2_cmd_t'(rand_bits(1));
    // Tag counts per source so order is visible at the target
    send_req(s, c, 4'(seq[s]), a, d);
    check_arrival(s, c, 4'(seq[s]), a, d);
    seq[s] = seq[s] + 1;
  end
endtask

/* dv/tb_ss_router.sv */
// Testbench top with clock, reset, DUT instance, timeout, LFSR and test sequence
`include "ss_router_cfg.svh"

module tb_ss_router;
  timeunit 1ns;
  timeprecision 1ps;

  // Reset plus body cycles of the six tests
  localparam int TEST_CYCLES    = 6 * 10 + 30 + 10 + 15 + 20 + 15 + 30 * 4;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic i_clk;
  logic rst_n;

  // Source side, index order is src_t
  logic [2:0]             s_valid;
  logic [2:0]             s_ready;
  ss_router_pkg::l2_cmd_t s_cmd [3];
  ss_router_pkg::tag_t    s_tag [3];
  ss_router_pkg::addr_t   s_addr [3];
  ss_router_pkg::data_t   s_data [3];
  logic [2:0]             s_rvalid;
  logic [2:0]             s_rready;
  ss_router_pkg::tag_t    s_rtag [3];
  ss_router_pkg::data_t   s_rdata [3];

  // Target side, index order is dest_t
  logic [2:0]              t_valid;
  logic [2:0]              t_ready;
  ss_router_pkg::l2_cmd_t  t_cmd [3];
  ss_router_pkg::ext_tag_t t_tag [3];
  ss_router_pkg::addr_t    t_addr [3];
  ss_router_pkg::data_t    t_data [3];
  logic [2:0]              t_rvalid;
  logic [2:0]              t_rready;
  ss_router_pkg::ext_tag_t t_rtag [3];
  ss_router_pkg::data_t    t_rdata [3];

  logic [15:0] lfsr;
  int          cycles;

  ss_router ss_router_inst (
    .i_clk(i_clk), .rst_n(rst_n),
    .ic_valid(s_valid[0]), .dc_valid(s_valid[1]), .ptw_valid(s_valid[2]),
    .ic_ready(s_ready[0]), .dc_ready(s_ready[1]), .ptw_ready(s_ready[2]),
    .ic_cmd(s_cmd[0]), .dc_cmd(s_cmd[1]), .ptw_cmd(s_cmd[2]),
    .ic_tag(s_tag[0]), .dc_tag(s_tag[1]), .ptw_tag(s_tag[2]),
    .ic_addr(s_addr[0]), .dc_addr(s_addr[1]), .ptw_addr(s_addr[2]),
    .ic_data(s_data[0]), .dc_data(s_data[1]), .ptw_data(s_data[2]),
    .ic_rvalid(s_rvalid[0]), .dc_rvalid(s_rvalid[1]), .ptw_rvalid(s_rvalid[2]),
    .ic_rready(s_rready[0]), .dc_rready(s_rready[1]), .ptw_rready(s_rready[2]),
    .ic_rtag(s_rtag[0]), .dc_rtag(s_rtag[1]), .ptw_rtag(s_rtag[2]),
    .ic_rdata(s_rdata[0]), .dc_rdata(s_rdata[1]), .ptw_rdata(s_rdata[2]),
    .clint_valid(t_valid[0]), .plic_valid(t_valid[1]), .l2_valid(t_valid[2]),
    .clint_ready(t_ready[0]), .plic_ready(t_ready[1]), .l2_ready(t_ready[2]),
    .clint_cmd(t_cmd[0]), .plic_cmd(t_cmd[1]), .l2_cmd(t_cmd[2]),
    .clint_tag(t_tag[0]), .plic_tag(t_tag[1]), .l2_tag(t_tag[2]),
    .clint_addr(t_addr[0]), .plic_addr(t_addr[1]), .l2_addr(t_addr[2]),
    .clint_data(t_data[0]), .plic_data(t_data[1]), .l2_data(t_data[2]),
    .clint_rvalid(t_rvalid[0]), .plic_rvalid(t_rvalid[1]), .l2_rvalid(t_rvalid[2]),
    .clint_rready(t_rready[0]), .plic_rready(t_rready[1]), .l2_rready(t_rready[2]),
    .clint_rtag(t_rtag[0]), .plic_rtag(t_rtag[1]), .l2_rtag(t_rtag[2]),
    .clint_rdata(t_rdata[0]), .plic_rdata(t_rdata[1]), .l2_rdata(t_rdata[2])
  );

  `include "tb_ss_router_tasks.svh"

  // 100 ns clock
  always begin
    #50 i_clk = ~i_clk;
  end

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, tests unfinished", cycles);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    i_clk    = 1'b0;
    rst_n    = 1'b0;
    cycles   = 0;
    lfsr     = 16'd16541;
    s_valid  = '0;
    s_rready = '0;
    t_ready  = '0;
    t_rvalid = '0;
    for (int i = 0; i < 3; i++) begin
      s_cmd[i]   = ss_router_pkg::CMD_RD;
      s_tag[i]   = '0;
      s_addr[i]  = '0;
      s_data[i]  = '0;
      t_rtag[i]  = '0;
      t_rdata[i] = '0;
    end
    test_decode();
    test_round_robin();
    test_back_pressure();
    test_resp_return();
    test_resp_arbitration();
    test_mixed_traffic();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* hdl/addr_decoder.sv */
// Address window decode and one-entry register slice toward the three targets
`include "ss_router_cfg.svh"

module addr_decoder (
  input  logic                     i_clk,
  input  logic                     rst_n,
  // Selected request from the arbiter
  input  logic                     sel_valid,
  output logic                     sel_ready,
  input  ss_router_pkg::l2_cmd_t   sel_cmd,
  input  ss_router_pkg::ext_tag_t  sel_tag,
  input  ss_router_pkg::addr_t     sel_addr,
  input  ss_router_pkg::data_t     sel_data,
  // Target requests in dest_t index order
  output logic [2:0]               tgt_valid,
  input  logic [2:0]               tgt_ready,
  output ss_router_pkg::l2_cmd_t   tgt_cmd,
  output ss_router_pkg::ext_tag_t  tgt_tag,
  output ss_router_pkg::addr_t     tgt_addr,
  output ss_router_pkg::data_t     tgt_data
);

  ss_router_pkg::dest_t dest_d;
  ss_router_pkg::dest_t dest_q;
  logic                 full_q;
  logic                 drain;
  logic                 accept;

  // --------------------------------------------------
  // Window decode
  // --------------------------------------------------
  always_comb begin
    dest_d = ss_router_pkg::DEST_L2;
    if ((sel_addr & ~`SS_CLINT_MASK) == `SS_CLINT_BASE) begin
      dest_d = ss_router_pkg::DEST_CLINT;
    end else if ((sel_addr & ~`SS_PLIC_MASK) == `SS_PLIC_BASE) begin
      dest_d = ss_router_pkg::DEST_PLIC;
    end
  end

  // --------------------------------------------------
  // Register slice
  // --------------------------------------------------
  // Refill allowed in the cycle the held entry leaves
  assign drain     = full_q & tgt_ready[dest_q];
  assign sel_ready = ~full_q | drain;
  assign accept    = sel_valid & sel_ready;

  always_ff @(posedge i_clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      dest_q   <= dest_d;
      tgt_cmd  <= sel_cmd;
      tgt_tag  <= sel_tag;
      tgt_addr <= sel_addr;
      tgt_data <= sel_data;
    end
  end

  // Only the decoded target sees valid
  always_comb begin
    tgt_valid         = '0;
    tgt_valid[dest_q] = full_q;
  end

  a_tgt_valid_onehot : assert property (
    @(posedge i_clk) disable iff (!rst_n)
    $onehot0(tgt_valid)
  );

endmodule

/* hdl/req_arbiter.sv */
// Round-robin request arbiter with grant lock and source index tag extension
module req_arbiter (
  input  logic                   i_clk,
  input  logic                   rst_n,
  // Source request groups in src_t index order
  input  logic [2:0]             src_valid,
  output logic [2:0]             src_ready,
  input  ss_router_pkg::l2_cmd_t src_cmd  [3],
  input  ss_router_pkg::tag_t    src_tag  [3],
  input  ss_router_pkg::addr_t   src_addr [3],
  input  ss_router_pkg::data_t   src_data [3],
  // Selected request toward the decoder
  output logic                     sel_valid,
  input  logic                     sel_ready,
  output ss_router_pkg::l2_cmd_t   sel_cmd,
  output ss_router_pkg::ext_tag_t  sel_tag,
  output ss_router_pkg::addr_t     sel_addr,
  output ss_router_pkg::data_t     sel_data
);

  ss_router_pkg::arb_ptr_t rr_ptr;
  ss_router_pkg::grant_t   grant;
  ss_router_pkg::grant_t   lock_gnt;
  ss_router_pkg::arb_ptr_t win;
  logic                    locked;
  logic                    sel_fire;

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------
  // A stalled grant is held until its transfer
  assign grant = locked ? lock_gnt : ss_router_pkg::rr_pick(src_valid, rr_ptr);
  assign win   = ss_router_pkg::gnt_idx(grant);

  assign sel_valid = |(grant & src_valid);
  assign sel_fire  = sel_valid & sel_ready;
  // Idle sources see the slice state, waiting ones only their grant
  assign src_ready = {3{sel_ready}} & (grant | ~src_valid);

  always_ff @(posedge i_clk) begin
    if (!rst_n) begin
      rr_ptr   <= '0;
      locked   <= 1'b0;
      lock_gnt <= '0;
    end else if (sel_fire) begin
      rr_ptr <= ss_router_pkg::rr_next(grant);
      locked <= 1'b0;
    end else if (sel_valid) begin
      locked   <= 1'b1;
      lock_gnt <= grant;
    end
  end

  // --------------------------------------------------
  // Payload mux and tag extension
  // --------------------------------------------------
  always_comb begin
    sel_cmd     = src_cmd[win];
    sel_addr    = src_addr[win];
    sel_data    = src_data[win];
    // Response path uses this prefix to find its way back
    sel_tag.src = ss_router_pkg::src_t'(win);
    sel_tag.tag = src_tag[win];
  end

  // Grant never names more than one source
  a_grant_onehot : assert property (
    @(posedge i_clk) disable iff (!rst_n)
    $onehot0(grant)
  );

  // Stalled grant stays on the same source until it transfers
  a_grant_locked : assert property (
    @(posedge i_clk) disable iff (!rst_n)
    (sel_valid && !sel_ready) |=> (grant == $past(grant))
  );

endmodule

/* hdl/resp_router.sv */
// Round-robin response arbiter with tag-based return routing and tag stripping
module resp_router (
  input  logic                     i_clk,
  input  logic                     rst_n,
  // Target responses in dest_t index order
  input  logic [2:0]               tgt_rvalid,
  output logic [2:0]               tgt_rready,
  input  ss_router_pkg::ext_tag_t  tgt_rtag  [3],
  input  ss_router_pkg::data_t     tgt_rdata [3],
  // Source responses in src_t index order
  output logic [2:0]               src_rvalid,
  input  logic [2:0]               src_rready,
  output ss_router_pkg::tag_t      src_rtag  [3],
  output ss_router_pkg::data_t     src_rdata [3]
);

  ss_router_pkg::arb_ptr_t rr_ptr;
  ss_router_pkg::grant_t   grant;
  ss_router_pkg::grant_t   lock_gnt;
  ss_router_pkg::arb_ptr_t win;
  ss_router_pkg::ext_tag_t win_tag;
  logic [1:0]              dst;
  logic                    locked;
  logic                    win_valid;
  logic                    dst_ready;
  logic                    resp_fire;

  // --------------------------------------------------
  // Target arbitration
  // --------------------------------------------------
  assign grant     = locked ? lock_gnt : ss_router_pkg::rr_pick(tgt_rvalid, rr_ptr);
  assign win       = ss_router_pkg::gnt_idx(grant);
  assign win_tag   = tgt_rtag[win];
  assign win_valid = |(grant & tgt_rvalid);
  assign dst       = win_tag.src;

  // Prefix 3 names no source and never gets a ready
  always_comb begin
    dst_ready = 1'b0;
    if (dst < 2'd3) begin
      dst_ready = src_rready[dst];
    end
  end

  assign tgt_rready = grant & {3{dst_ready}};
  assign resp_fire  = win_valid & dst_ready;

  always_ff @(posedge i_clk) begin
    if (!rst_n) begin
      rr_ptr   <= '0;
      locked   <= 1'b0;
      lock_gnt <= '0;
    end else if (resp_fire) begin
      rr_ptr <= ss_router_pkg::rr_next(grant);
      locked <= 1'b0;
    end else if (win_valid) begin
      locked   <= 1'b1;
      lock_gnt <= grant;
    end
  end

  // --------------------------------------------------
  // Return routing
  // --------------------------------------------------
  // Prefix stripped here so sources see only their own tag
  always_comb begin
    for (int s = 0; s < 3; s++) begin
      src_rvalid[s] = win_valid && (dst == 2'(s));
      src_rtag[s]   = win_tag.tag;
      src_rdata[s]  = tgt_rdata[win];
    end
  end

  a_rtag_src_valid : assert property (
    @(posedge i_clk) disable iff (!rst_n)
    win_valid |-> (dst != 2'd3)
  );

endmodule

/* hdl/ss_router.sv */
// Subsystem request router top connecting arbiter, decoder and response router
module ss_router (
  input  logic                     i_clk,
  input  logic                     rst_n,
  // --------------------------------------------------
  // Source side: icache, dcache, page-table walker
  // --------------------------------------------------
  input  logic                     ic_valid, dc_valid, ptw_valid,
  output logic                     ic_ready, dc_ready, ptw_ready,
  input  ss_router_pkg::l2_cmd_t   ic_cmd, dc_cmd, ptw_cmd,
  input  ss_router_pkg::tag_t      ic_tag, dc_tag, ptw_tag,
  input  ss_router_pkg::addr_t     ic_addr, dc_addr, ptw_addr,
  input  ss_router_pkg::data_t     ic_data, dc_data, ptw_data,
  output logic                     ic_rvalid, dc_rvalid, ptw_rvalid,
  input  logic                     ic_rready, dc_rready, ptw_rready,
  output ss_router_pkg::tag_t      ic_rtag, dc_rtag, ptw_rtag,
  output ss_router_pkg::data_t     ic_rdata, dc_rdata, ptw_rdata,
  // --------------------------------------------------
  // Target side: CLINT, PLIC, L2
  // --------------------------------------------------
  output logic                     clint_valid, plic_valid, l2_valid,
  input  logic                     clint_ready, plic_ready, l2_ready,
  output ss_router_pkg::l2_cmd_t   clint_cmd, plic_cmd, l2_cmd,
  output ss_router_pkg::ext_tag_t  clint_tag, plic_tag, l2_tag,
  output ss_router_pkg::addr_t     clint_addr, plic_addr, l2_addr,
  output ss_router_pkg::data_t     clint_data, plic_data, l2_data,
  input  logic                     clint_rvalid, plic_rvalid, l2_rvalid,
  output logic                     clint_rready, plic_rready, l2_rready,
  input  ss_router_pkg::ext_tag_t  clint_rtag, plic_rtag, l2_rtag,
  input  ss_router_pkg::data_t     clint_rdata, plic_rdata, l2_rdata
);

  // Arbiter to decoder link
  logic                    sel_valid;
  logic                    sel_ready;
  ss_router_pkg::l2_cmd_t  sel_cmd;
  ss_router_pkg::ext_tag_t sel_tag;
  ss_router_pkg::addr_t    sel_addr;
  ss_router_pkg::data_t    sel_data;

  // Shared target payload
  ss_router_pkg::l2_cmd_t  tgt_cmd;
  ss_router_pkg::ext_tag_t tgt_tag;
  ss_router_pkg::addr_t    tgt_addr;
  ss_router_pkg::data_t    tgt_data;

  // Returned responses per source
  ss_router_pkg::tag_t     src_rtag  [3];
  ss_router_pkg::data_t    src_rdata [3];

  req_arbiter u_req_arbiter (
    .i_clk     (i_clk),
    .rst_n     (rst_n),
    .src_valid ({ptw_valid, dc_valid, ic_valid}),
    .src_ready ({ptw_ready, dc_ready, ic_ready}),
    .src_cmd   ('{ic_cmd, dc_cmd, ptw_cmd}),
    .src_tag   ('{ic_tag, dc_tag, ptw_tag}),
    .src_addr  ('{ic_addr, dc_addr, ptw_addr}),
    .src_data  ('{ic_data, dc_data, ptw_data}),
    .sel_valid (sel_valid),
    .sel_ready (sel_ready),
    .sel_cmd   (sel_cmd),
    .sel_tag   (sel_tag),
    .sel_addr  (sel_addr),
    .sel_data  (sel_data)
  );

  addr_decoder u_addr_decoder (
    .i_clk     (i_clk),
    .rst_n     (rst_n),
    .sel_valid (sel_valid),
    .sel_ready (sel_ready),
    .sel_cmd   (sel_cmd),
    .sel_tag   (sel_tag),
    .sel_addr  (sel_addr),
    .sel_data  (sel_data),
    .tgt_valid ({l2_valid, plic_valid, clint_valid}),
    .tgt_ready ({l2_ready, plic_ready, clint_ready}),
    .tgt_cmd   (tgt_cmd),
    .tgt_tag   (tgt_tag),
    .tgt_addr  (tgt_addr),
    .tgt_data  (tgt_data)
  );

  assign clint_cmd  = tgt_cmd;
  assign plic_cmd   = tgt_cmd;
  assign l2_cmd     = tgt_cmd;
  assign clint_tag  = tgt_tag;
  assign plic_tag   = tgt_tag;
  assign l2_tag     = tgt_tag;
  assign clint_addr = tgt_addr;
  assign plic_addr  = tgt_addr;
  assign l2_addr    = tgt_addr;
  assign clint_data = tgt_data;
  assign plic_data  = tgt_data;
  assign l2_data    = tgt_data;

  resp_router u_resp_router (
    .i_clk      (i_clk),
    .rst_n      (rst_n),
    .tgt_rvalid ({l2_rvalid, plic_rvalid, clint_rvalid}),
    .tgt_rready ({l2_rready, plic_rready, clint_rready}),
    .tgt_rtag   ('{clint_rtag, plic_rtag, l2_rtag}),
    .tgt_rdata  ('{clint_rdata, plic_rdata, l2_rdata}),
    .src_rvalid ({ptw_rvalid, dc_rvalid, ic_rvalid}),
    .src_rready ({ptw_rready, dc_rready, ic_rready}),
    .src_rtag   (src_rtag),
    .src_rdata  (src_rdata)
  );

  assign ic_rtag   = src_rtag[0];
  assign dc_rtag   = src_rtag[1];
  assign ptw_rtag  = src_rtag[2];
  assign ic_rdata  = src_rdata[0];
  assign dc_rdata  = src_rdata[1];
  assign ptw_rdata = src_rdata[2];

endmodule

/* hdl/ss_router_cfg.svh */
// Width and address window macros for the subsystem request router
`ifndef SS_ROUTER_CFG_SVH
`define SS_ROUTER_CFG_SVH

// --------------------------------------------------
// Field widths
// --------------------------------------------------
// Tag as issued by each source
`define SS_TAG_W 4
`define SS_ADDR_W 32
`define SS_DATA_W 32
// Source index carried above the tag
`define SS_SRC_ID_W 2

// --------------------------------------------------
// Target address windows
// --------------------------------------------------
// CLINT, 4 MiB window
`define SS_CLINT_BASE 32'h0200_0000
`define SS_CLINT_MASK 32'h003f_ffff
// PLIC, 16 MiB window
`define SS_PLIC_BASE 32'h0c00_0000
`define SS_PLIC_MASK 32'h00ff_ffff

`endif

/* hdl/ss_router_pkg.sv */
// Command, destination, source, tag and round-robin arbiter types and helpers
`include "ss_router_cfg.svh"

package ss_router_pkg;

  typedef enum logic {CMD_RD = 1'b0, CMD_WR = 1'b1} l2_cmd_t;

  // Target order, also the index order of the target vectors
  typedef enum logic [1:0] {DEST_CLINT = 2'd0, DEST_PLIC = 2'd1, DEST_L2 = 2'd2} dest_t;

  typedef enum logic [`SS_SRC_ID_W-1:0] {SRC_IC = 2'd0, SRC_DC = 2'd1, SRC_PTW = 2'd2} src_t;

  typedef logic [`SS_TAG_W-1:0]  tag_t;
  typedef logic [`SS_ADDR_W-1:0] addr_t;
  typedef logic [`SS_DATA_W-1:0] data_t;

  // Source index on top, source tag below
  typedef struct packed {
    src_t src;
    tag_t tag;
  } ext_tag_t;

  // --------------------------------------------------
  // Round-robin arbiter over three requesters
  // --------------------------------------------------
  typedef logic [2:0] grant_t;
  typedef logic [`SS_SRC_ID_W-1:0] arb_ptr_t;

  // One-hot pick, search starts at ptr
  function automatic grant_t rr_pick(grant_t req, arb_ptr_t ptr);
    grant_t gnt;
    int unsigned idx;
    gnt = '0;
    for (int unsigned k = 0; k < 3; k++) begin
      idx = (ptr + k) % 3;
      if (gnt == '0 && req[idx]) begin
        gnt[idx] = 1'b1;
      end
    end
    return gnt;
  endfunction

  // Index of a one-hot grant, 0 when empty
  function automatic arb_ptr_t gnt_idx(grant_t gnt);
    arb_ptr_t idx;
    idx = '0;
    if (gnt[1]) begin
      idx = 2'd1;
    end
    if (gnt[2]) begin
      idx = 2'd2;
    end
    return idx;
  endfunction

  // Winner k hands top priority to k+1 mod 3
  function automatic arb_ptr_t rr_next(grant_t gnt);
    arb_ptr_t nxt;
    nxt = 2'd0;
    if (gnt[0]) begin
      nxt = 2'd1;
    end
    if (gnt[1]) begin
      nxt = 2'd2;
    end
    return nxt;
  endfunction

endpackage

/* verilog.f */
+incdir+hdl
+incdir+dv
hdl/ss_router_pkg.sv
hdl/req_arbiter.sv
hdl/addr_decoder.sv
hdl/resp_router.sv
hdl/ss_router.sv
dv/tb_ss_router.sv
